// File: source/axis_pkg.sv
// Stream pipeline definitions
`default_nettype none

package axis_pkg;

    // payload width of tdata
    localparam int data_width = 8;

    // fifo holds 2**fifo_addr_width words
    localparam int fifo_addr_width = 4;

    // frame counters wrap at this width
    localparam int count_width = 16;

    // skid register occupancy
    // idle has nothing stored, transfer holds the output word,
    // transfer_wait holds the output word plus one in temp
    typedef enum logic [1:0] {
        idle          = 2'd0,
        transfer      = 2'd1,
        transfer_wait = 2'd2
    } reg_state_t;

endpackage

`default_nettype wire

// File: source/axis_if.sv
// AXI-Stream bus
`timescale 1ns/1ps
`default_nettype none

interface axis_if import axis_pkg::*; ();

    // payload
    logic [data_width-1:0] tdata;
    logic                  tlast;
    // single bit, set on the last word marks a bad frame
    logic                  tuser;

    // handshake
    logic                  tvalid;
    logic                  tready;

    // block that produces words
    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    // block that consumes words
    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

    // passive observer
    modport monitor (
        input tdata, tvalid, tready, tlast, tuser
    );

endinterface

`default_nettype wire

// File: source/axis_register.sv
// AXI-Stream skid register slice
`timescale 1ns/1ps
`default_nettype none

module axis_register import axis_pkg::*; (
    input logic    clk,
    input logic    rst,
    axis_if.sink   s,
    axis_if.source m
);

    reg_state_t state;
    reg_state_t state_next;

    // datapath moves picked by the fsm
    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // accepted input word this cycle
    logic in_hs;

    // registered handshake outputs
    logic ready_reg;
    logic valid_reg;

    // output register
    logic [data_width-1:0] out_tdata;
    logic                  out_tlast;
    logic                  out_tuser;

    // skid register, catches the word taken while the output stalls
    logic [data_width-1:0] temp_tdata;
    logic                  temp_tlast;
    logic                  temp_tuser;

    assign in_hs = s.tvalid && s.tready;

    assign s.tready = ready_reg;
    assign m.tvalid = valid_reg;
    assign m.tdata  = out_tdata;
    assign m.tlast  = out_tlast;
    assign m.tuser  = out_tuser;

    always_comb begin
        state_next  = state;
        in_to_out   = 1'b0;
        in_to_temp  = 1'b0;
        temp_to_out = 1'b0;
        case (state)
            idle: begin
                // empty, first word goes straight to the output
                if (in_hs) begin
                    in_to_out  = 1'b1;
                    state_next = transfer;
                end
            end
            transfer: begin
                if (in_hs && m.tready) begin
                    // flow through, replace the output word
                    in_to_out = 1'b1;
                end else if (!in_hs && m.tready) begin
                    state_next = idle;
                end else if (in_hs && !m.tready) begin
                    // output stalled, park the new word
                    in_to_temp = 1'b1;
                    state_next = transfer_wait;
                end
            end
            transfer_wait: begin
                // both full, drain temp once the output moves
                if (m.tready) begin
                    temp_to_out = 1'b1;
                    state_next  = transfer;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            ready_reg <= 1'b0;
            valid_reg <= 1'b0;
        end else begin
            state     <= state_next;
            // tready looks at the next state only, so no input-to-ready path
            ready_reg <= (state_next != transfer_wait);
            valid_reg <= (state_next != idle);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_tdata <= s.tdata;
            out_tlast <= s.tlast;
            out_tuser <= s.tuser;
        end else if (in_to_temp) begin
            temp_tdata <= s.tdata;
            temp_tlast <= s.tlast;
            temp_tuser <= s.tuser;
        end else if (temp_to_out) begin
            out_tdata <= temp_tdata;
            out_tlast <= temp_tlast;
            out_tuser <= temp_tuser;
        end
    end

    // temp occupied means no room for another word
    a_no_ready_in_wait: assert property (@(posedge clk) disable iff (rst)
        (state == transfer_wait) |-> !s.tready);

    // a stalled word is not withdrawn
    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        (m.tvalid && !m.tready) |=> m.tvalid);

    // nor does its payload change
    a_payload_held: assert property (@(posedge clk) disable iff (rst)
        (m.tvalid && !m.tready) |=> $stable({m.tdata, m.tlast, m.tuser}));

endmodule

`default_nettype wire

// File: source/axis_fifo.sv
// AXI-Stream synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module axis_fifo import axis_pkg::*; #(
    parameter int addr_width = fifo_addr_width
) (
    input logic    clk,
    input logic    rst,
    axis_if.sink   s,
    axis_if.source m
);

    localparam int depth      = 2 ** addr_width;
    // stored word is {tlast, tuser, tdata}
    localparam int word_width = data_width + 2;

    logic [word_width-1:0] mem [depth];

    // pointers carry one extra wrap bit
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;

    // occupancy, only checked
    logic [addr_width:0] fill;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    logic [word_width-1:0] wr_word;
    logic [word_width-1:0] rd_word;

    // same index with different wrap bit means the writer lapped the reader
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign fill  = wr_ptr - rd_ptr;

    assign s.tready = !full;
    assign m.tvalid = !empty;

    assign wr_en = s.tvalid && !full;
    assign rd_en = m.tready && !empty;

    assign wr_word = {s.tlast, s.tuser, s.tdata};

    // asynchronous read, a written word shows at the head one cycle later
    assign rd_word = mem[rd_ptr[addr_width-1:0]];
    assign m.tlast = rd_word[word_width-1];
    assign m.tuser = rd_word[word_width-2];
    assign m.tdata = rd_word[data_width-1:0];

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[addr_width-1:0]] <= wr_word;
        end
    end

    // write side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // a full fifo leaves the write pointer where it was
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        full |=> (wr_ptr == $past(wr_ptr)));

    // never more words than slots
    a_fill_bound: assert property (@(posedge clk) disable iff (rst)
        fill <= depth);

endmodule

`default_nettype wire

// File: source/axis_frame_stats.sv
// Frame and error frame counters
`timescale 1ns/1ps
`default_nettype none

module axis_frame_stats import axis_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    axis_if.monitor                mon,
    output logic [count_width-1:0] frame_count,
    output logic [count_width-1:0] bad_frame_count
);

    // last word of a frame crossed the bus
    logic frame_end;
    // same, with the error flag on that word
    logic bad_end;

    assign frame_end = mon.tvalid && mon.tready && mon.tlast;
    assign bad_end   = frame_end && mon.tuser;

    // both counters wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_count     <= '0;
            bad_frame_count <= '0;
        end else begin
            if (frame_end) begin
                frame_count <= frame_count + 1'b1;
            end
            if (bad_end) begin
                bad_frame_count <= bad_frame_count + 1'b1;
            end
        end
    end

    // every bad frame is a frame too
    a_bad_implies_frame: assert property (@(posedge clk) disable iff (rst)
        $changed(bad_frame_count) |-> $changed(frame_count));

endmodule

`default_nettype wire

// File: source/axis_pipeline.sv
// Buffered AXI-Stream pipeline
`timescale 1ns/1ps
`default_nettype none

module axis_pipeline import axis_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // input stream
    input  logic [data_width-1:0]  s_tdata,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  logic                   s_tuser,
    // output stream
    output logic [data_width-1:0]  m_tdata,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output logic                   m_tlast,
    output logic                   m_tuser,
    // statistics
    output logic [count_width-1:0] frame_count,
    output logic [count_width-1:0] bad_frame_count
);

    // bus from the input ports into the first slice
    axis_if in_bus ();
    axis_if in_to_fifo ();
    axis_if fifo_to_out ();
    axis_if out_bus ();

    assign in_bus.tdata  = s_tdata;
    assign in_bus.tvalid = s_tvalid;
    assign in_bus.tlast  = s_tlast;
    assign in_bus.tuser  = s_tuser;
    assign s_tready      = in_bus.tready;

    assign out_bus.tready = m_tready;
    assign m_tdata        = out_bus.tdata;
    assign m_tvalid       = out_bus.tvalid;
    assign m_tlast        = out_bus.tlast;
    assign m_tuser        = out_bus.tuser;

    // input slice, 2 words
    axis_register in_reg_i (
        .clk (clk),
        .rst (rst),
        .s   (in_bus.sink),
        .m   (in_to_fifo.source)
    );

    // main buffer, 16 words
    axis_fifo #(
        .addr_width (fifo_addr_width)
    ) fifo_i (
        .clk (clk),
        .rst (rst),
        .s   (in_to_fifo.sink),
        .m   (fifo_to_out.source)
    );

    // output slice, 2 words
    axis_register out_reg_i (
        .clk (clk),
        .rst (rst),
        .s   (fifo_to_out.sink),
        .m   (out_bus.source)
    );

    // watches the output handshake
    axis_frame_stats stats_i (
        .clk             (clk),
        .rst             (rst),
        .mon             (out_bus.monitor),
        .frame_count     (frame_count),
        .bad_frame_count (bad_frame_count)
    );

endmodule

`default_nettype wire

// File: dv/axis_pipeline_tb.sv
// Stream pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module axis_pipeline_tb import axis_pkg::*; ();

    // 2 + 16 + 2 words of buffering
    localparam int capacity    = 20;
    localparam int offered     = 30;
    localparam int stall_min   = 50;
    localparam int stall_limit = 60;
    localparam int wait_limit  = 200;
    localparam int seed_init   = 84;

    logic                   clk;
    logic                   rst;
    logic [data_width-1:0]  s_tdata;
    logic                   s_tvalid;
    logic                   s_tready;
    logic                   s_tlast;
    logic                   s_tuser;
    logic [data_width-1:0]  m_tdata;
    logic                   m_tvalid;
    logic                   m_tready;
    logic                   m_tlast;
    logic                   m_tuser;
    logic [count_width-1:0] frame_count;
    logic [count_width-1:0] bad_frame_count;

    integer      seed;
    int          error_count;
    int          timeout_count;
    int          rx_count;
    logic        hung;
    string       test_name;
    // 0 ready high, 1 random, 2 held low
    logic [1:0]  ready_mode;
    logic [31:0] ready_rnd;

    // expected words as {tlast, tuser, tdata}, in acceptance order
    logic [data_width+1:0] exp_q [$];

    axis_pipeline dut_i (
        .clk             (clk),
        .rst             (rst),
        .s_tdata         (s_tdata),
        .s_tvalid        (s_tvalid),
        .s_tready        (s_tready),
        .s_tlast         (s_tlast),
        .s_tuser         (s_tuser),
        .m_tdata         (m_tdata),
        .m_tvalid        (m_tvalid),
        .m_tready        (m_tready),
        .m_tlast         (m_tlast),
        .m_tuser         (m_tuser),
        .frame_count     (frame_count),
        .bad_frame_count (bad_frame_count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] want,
                               input logic [31:0] got);
        if (got !== want) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, want, got);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        timeout_count++;
        hung = 1'b1;
    endtask

    // pop and compare one output word
    task automatic check_output();
        logic [data_width+1:0] got;
        logic [data_width+1:0] want;
        got = {m_tlast, m_tuser, m_tdata};
        rx_count++;
        if (exp_q.size() == 0) begin
            $display("unexpected output word %h in test %s", got, test_name);
            error_count++;
        end else begin
            want = exp_q.pop_front();
            check_value("output word", want, got);
        end
    endtask

    // sink side, ready set after the edge and handshake seen mid cycle
    always begin
        @(posedge clk);
        #1;
        ready_rnd = $random(seed);
        case (ready_mode)
            2'd0:    m_tready = 1'b1;
            2'd1:    m_tready = ready_rnd[0];
            default: m_tready = 1'b0;
        endcase
        @(negedge clk);
        if (m_tvalid && m_tready) begin
            check_output();
        end
    end

    // called and returns 1 ns after a rising edge
    task automatic send_word(input logic [data_width-1:0] d, input logic last,
                             input logic user);
        int waited;
        waited = 0;
        s_tdata  = d;
        s_tlast  = last;
        s_tuser  = user;
        s_tvalid = 1'b1;
        while (!hung) begin
            @(negedge clk);
            if (s_tready) begin
                // taken on the coming edge
                exp_q.push_back({last, user, d});
                @(posedge clk);
                #1;
                break;
            end
            waited++;
            if (waited > wait_limit) begin
                report_timeout("s_tready");
            end
            @(posedge clk);
            #1;
        end
        s_tvalid = 1'b0;
    endtask

    task automatic send_frame(input int len, input logic bad, input logic [7:0] base);
        for (int i = 0; i < len; i++) begin
            send_word(base + i[7:0], i == len - 1, bad && (i == len - 1));
        end
    endtask

    task automatic wait_ready(input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!s_tready && !hung) begin
            waited++;
            if (waited > limit) begin
                report_timeout(what);
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    // ends one edge after the last pop so the counters have settled
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !hung) begin
            @(posedge clk);
            waited++;
            if (waited > wait_limit) begin
                report_timeout("output to drain");
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset();
        test_name = "reset";
        rst = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_value("m_tvalid", 0, m_tvalid);
            check_value("s_tready", 0, s_tready);
            check_value("frame_count", 0, frame_count);
            check_value("bad_frame_count", 0, bad_frame_count);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        wait_ready(5, "s_tready after reset");
        check_value("m_tvalid", 0, m_tvalid);
        check_value("frame_count", 0, frame_count);
        check_value("bad_frame_count", 0, bad_frame_count);
    endtask

    task automatic test_pass_through();
        int rx0;
        test_name  = "pass_through";
        ready_mode = 2'd0;
        rx0        = rx_count;
        send_frame(8, 1'b0, 8'h40);
        wait_drain();
        check_value("word count", 8, rx_count - rx0);
    endtask

    task automatic test_random();
        logic [data_width+1:0] words [$];
        logic [31:0]           rnd;
        int                    len;
        int                    rx0;
        test_name = "random";
        // draw every word up front, before any of them is sent
        for (int f = 0; f < 5; f++) begin
            rnd = $random(seed);
            len = 1 + rnd[2:0];
            for (int i = 0; i < len; i++) begin
                rnd = $random(seed);
                words.push_back({i == len - 1, rnd[8] && (i == len - 1), rnd[7:0]});
            end
        end
        ready_mode = 2'd1;
        rx0        = rx_count;
        foreach (words[i]) begin
            send_word(words[i][data_width-1:0], words[i][data_width+1], words[i][data_width]);
        end
        wait_drain();
        check_value("word count", words.size(), rx_count - rx0);
    endtask

    task automatic test_capacity();
        int idx;
        int stall;
        int rx0;
        test_name  = "capacity";
        ready_mode = 2'd2;
        rx0        = rx_count;
        idx        = 0;
        stall      = 0;
        @(posedge clk);
        #1;
        s_tdata  = 8'h80;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
        s_tvalid = 1'b1;
        // keep offering until 30 are taken or tready stays low long enough
        while (idx < offered && stall < stall_limit && !hung) begin
            @(negedge clk);
            if (s_tready) begin
                exp_q.push_back({2'b00, s_tdata});
                idx++;
                stall = 0;
            end else begin
                stall++;
            end
            @(posedge clk);
            #1;
            s_tdata = 8'h80 + idx[7:0];
        end
        s_tvalid = 1'b0;
        check_value("accepted words", capacity, idx);
        if (stall < stall_min) begin
            $display("s_tready did not stay low under back-pressure in test %s", test_name);
            error_count++;
        end
        // first offered word waits at the output
        check_value("m_tvalid while stalled", 1, m_tvalid);
        check_value("head word while stalled", {2'b00, 8'h80}, {m_tlast, m_tuser, m_tdata});
        ready_mode = 2'd0;
        wait_drain();
        check_value("word count", capacity, rx_count - rx0);
        wait_ready(10, "s_tready after drain");
    endtask

    task automatic test_stats();
        logic [count_width-1:0] fc0;
        logic [count_width-1:0] bc0;
        logic [count_width-1:0] dframes;
        logic [count_width-1:0] dbad;
        test_name  = "frame_stats";
        fc0        = frame_count;
        bc0        = bad_frame_count;
        ready_mode = 2'd1;
        // odd frames carry tuser on their last word
        for (int i = 0; i < 6; i++) begin
            send_frame(3, i % 2 == 1, 8'h10 * i[7:0]);
        end
        wait_drain();
        dframes = frame_count - fc0;
        dbad    = bad_frame_count - bc0;
        check_value("frame_count delta", 6, dframes);
        check_value("bad_frame_count delta", 3, dbad);
    endtask

    initial begin
        seed          = seed_init;
        error_count   = 0;
        timeout_count = 0;
        rx_count      = 0;
        hung          = 1'b0;
        ready_mode    = 2'd0;
        test_name     = "init";
        rst           = 1'b1;
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        s_tlast       = 1'b0;
        s_tuser       = 1'b0;
        m_tready      = 1'b0;

        test_reset();
        if (!hung) begin
            test_pass_through();
        end
        if (!hung) begin
            test_random();
        end
        if (!hung) begin
            test_capacity();
        end
        if (!hung) begin
            test_stats();
        end

        $display("summary: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/axis_pkg.sv
source/axis_if.sv
source/axis_register.sv
source/axis_fifo.sv
source/axis_frame_stats.sv
source/axis_pipeline.sv
dv/axis_pipeline_tb.sv
